// File: Makefile
TOP = tge_tx_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module tge_tx_top

clean:
	rm -rf obj_dir sim.log

// File: compile.f
tge_pkg.sv
tge_beat_if.sv
tge_tx_buffer.sv
tge_tx_header.sv
tge_tx_mac_out.sv
tge_tx_top.sv
tge_tx_tb.sv

// File: tge_beat_if.sv
`timescale 1ns/1ps

interface tge_beat_if;
  import tge_pkg::*;

  logic  valid;
  word_t data;
  logic  last;
  // Frame metadata, meaningful on the first beat only
  ip_t   dest_ip;
  port_t dest_port;
  len_t  len;
  // One pulse per freed receiver slot
  logic  credit;

  modport sender (
    output valid, data, last, dest_ip, dest_port, len,
    input  credit
  );

  modport receiver (
    input  valid, data, last, dest_ip, dest_port, len,
    output credit
  );

endinterface

// File: tge_pkg.sv
package tge_pkg;

  typedef logic [63:0] word_t;
  typedef logic [31:0] ip_t;
  typedef logic [15:0] port_t;
  typedef logic [15:0] len_t;
  typedef logic [15:0] seq_t;

  localparam int HDR_WORDS = 2;

  // Header word 0 field positions
  localparam int W0_DEST_IP_LSB    = 32;
  localparam int W0_DEST_PORT_LSB  = 16;
  localparam int W0_LOCAL_PORT_LSB = 0;

  // Header word 1 field positions
  localparam int W1_LOCAL_IP_LSB = 32;
  localparam int W1_LEN_LSB      = 16;
  localparam int W1_SEQ_LSB      = 0;

  function automatic word_t hdr_word0(ip_t dest_ip, port_t dest_port, port_t local_port);
    word_t w;
    w = '0;
    w[W0_DEST_IP_LSB +: $bits(ip_t)]      = dest_ip;
    w[W0_DEST_PORT_LSB +: $bits(port_t)]  = dest_port;
    w[W0_LOCAL_PORT_LSB +: $bits(port_t)] = local_port;
    return w;
  endfunction

  function automatic word_t hdr_word1(ip_t local_ip, len_t len, seq_t seq);
    word_t w;
    w = '0;
    w[W1_LOCAL_IP_LSB +: $bits(ip_t)] = local_ip;
    w[W1_LEN_LSB +: $bits(len_t)]     = len;
    w[W1_SEQ_LSB +: $bits(seq_t)]     = seq;
    return w;
  endfunction

endpackage

// File: tge_tx_buffer.sv
`timescale 1ns/1ps

module tge_tx_buffer #(
  parameter int BUF_DEPTH = 64,
  parameter int AFULL_GAP = 8,
  parameter int CREDITS   = 4
) (
  input  logic             clk,
  input  logic             mac_resetRR,
  input  logic             tx_valid,
  input  logic             tx_end_of_frame,
  input  tge_pkg::word_t   tx_data,
  input  tge_pkg::ip_t     tx_dest_ip,
  input  tge_pkg::port_t   tx_dest_port,
  output logic             tx_overflow,
  output logic             tx_afull,
  tge_beat_if.sender       hdr
);
  import tge_pkg::*;

  localparam int AW = $clog2(BUF_DEPTH);
  localparam int CW = $clog2(CREDITS + 1);

  word_t mem [BUF_DEPTH];
  ip_t   meta_ip [BUF_DEPTH];
  port_t meta_port [BUF_DEPTH];
  len_t  meta_len [BUF_DEPTH];

  logic [AW:0] wr_ptr, wr_base, rd_ptr, used, free;
  logic [AW:0] mq_wr, mq_rd, mq_cnt;
  logic        in_frame, dropping, full, wr_en, commit;
  len_t        frm_len, rd_left;
  ip_t         frm_ip, cur_ip;
  port_t       frm_port, cur_port;
  logic        active, send, last_send, load;
  logic [CW-1:0] cnt;

  assign used   = wr_ptr - rd_ptr;
  assign free   = (AW+1)'(BUF_DEPTH) - used;
  assign full   = used == (AW+1)'(BUF_DEPTH);
  assign wr_en  = tx_valid && !dropping && !full;
  assign commit = wr_en && tx_end_of_frame;
  assign mq_cnt = mq_wr - mq_rd;

  // Write side, speculative pointer rewinds on overflow
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      wr_ptr      <= '0;
      wr_base     <= '0;
      mq_wr       <= '0;
      frm_len     <= '0;
      in_frame    <= 1'b0;
      dropping    <= 1'b0;
      tx_overflow <= 1'b0;
      tx_afull    <= 1'b0;
    end else begin
      tx_overflow <= 1'b0;
      tx_afull    <= free <= (AW+1)'(AFULL_GAP);
      if (tx_valid && dropping) begin
        dropping <= !tx_end_of_frame;
      end else if (tx_valid && full) begin
        tx_overflow <= 1'b1;
        wr_ptr      <= wr_base;
        frm_len     <= '0;
        in_frame    <= 1'b0;
        dropping    <= !tx_end_of_frame;
      end else if (wr_en) begin
        wr_ptr   <= wr_ptr + 1'b1;
        in_frame <= !tx_end_of_frame;
        frm_len  <= tx_end_of_frame ? '0 : frm_len + 1'b1;
        if (tx_end_of_frame) begin
          wr_base <= wr_ptr + 1'b1;
          mq_wr   <= mq_wr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= tx_data;
      if (!in_frame) begin
        frm_ip   <= tx_dest_ip;
        frm_port <= tx_dest_port;
      end
    end
    if (commit) begin
      meta_ip[mq_wr[AW-1:0]]   <= in_frame ? frm_ip : tx_dest_ip;
      meta_port[mq_wr[AW-1:0]] <= in_frame ? frm_port : tx_dest_port;
      meta_len[mq_wr[AW-1:0]]  <= frm_len + 1'b1;
    end
  end

  // Read side streams one committed frame at a time
  assign send      = active && (cnt != '0 || hdr.credit);
  assign last_send = send && rd_left == len_t'(1);
  assign load      = mq_cnt != '0 && (!active || last_send);

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      rd_ptr    <= '0;
      mq_rd     <= '0;
      rd_left   <= '0;
      active    <= 1'b0;
      cnt       <= CW'(CREDITS);
      hdr.valid <= 1'b0;
      hdr.last  <= 1'b0;
    end else begin
      hdr.valid <= send;
      hdr.last  <= last_send;
      cnt       <= cnt - CW'(send) + CW'(hdr.credit);
      if (send) begin
        rd_ptr  <= rd_ptr + 1'b1;
        rd_left <= rd_left - 1'b1;
      end
      if (load) begin
        mq_rd   <= mq_rd + 1'b1;
        rd_left <= meta_len[mq_rd[AW-1:0]];
        active  <= 1'b1;
      end else if (last_send) begin
        active <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      cur_ip   <= meta_ip[mq_rd[AW-1:0]];
      cur_port <= meta_port[mq_rd[AW-1:0]];
    end
    if (send) begin
      hdr.data      <= mem[rd_ptr[AW-1:0]];
      hdr.dest_ip   <= cur_ip;
      hdr.dest_port <= cur_port;
      hdr.len       <= rd_left;
    end
  end

  // Only committed words may leave the buffer
  assert property (@(posedge clk) disable iff (mac_resetRR)
    send |-> rd_ptr != wr_base);
  assert property (@(posedge clk) disable iff (mac_resetRR)
    cnt <= CW'(CREDITS));

endmodule

// File: tge_tx_header.sv
`timescale 1ns/1ps

module tge_tx_header #(
  parameter int CREDITS = 4
) (
  input  logic           clk,
  input  logic           mac_resetRR,
  input  tge_pkg::ip_t   local_ip,
  input  tge_pkg::port_t local_port,
  tge_beat_if.receiver   in_beat,
  tge_beat_if.sender     out_beat
);
  import tge_pkg::*;

  localparam int CW = $clog2(CREDITS + 1);
  localparam int IW = $clog2(CREDITS);

  typedef enum logic [1:0] {IDLE, HDR0, HDR1, PAYLOAD} state_t;

  state_t state;

  // Holding FIFO for incoming beats
  word_t f_data [CREDITS];
  logic  f_last [CREDITS];
  ip_t   f_ip [CREDITS];
  port_t f_port [CREDITS];
  len_t  f_len [CREDITS];

  logic [IW-1:0] wr_ix, rd_ix;
  logic [CW-1:0] f_cnt, o_cnt;
  logic  push, pop, can_send, have_frame;
  ip_t   src_ip, m_ip;
  port_t src_port, m_port;
  len_t  src_len, m_len;
  seq_t  seq;

  assign push     = in_beat.valid;
  assign can_send = o_cnt != '0 || out_beat.credit;
  assign pop      = state == PAYLOAD && f_cnt != '0 && can_send;

  // Empty FIFO in IDLE lets the arriving first beat start the header
  assign have_frame = f_cnt != '0 || in_beat.valid;
  assign src_ip     = f_cnt != '0 ? f_ip[rd_ix] : in_beat.dest_ip;
  assign src_port   = f_cnt != '0 ? f_port[rd_ix] : in_beat.dest_port;
  assign src_len    = f_cnt != '0 ? f_len[rd_ix] : in_beat.len;

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      state          <= IDLE;
      wr_ix          <= '0;
      rd_ix          <= '0;
      f_cnt          <= '0;
      o_cnt          <= CW'(CREDITS);
      seq            <= '0;
      in_beat.credit <= 1'b0;
      out_beat.valid <= 1'b0;
      out_beat.last  <= 1'b0;
    end else begin
      in_beat.credit <= pop;
      out_beat.valid <= 1'b0;
      out_beat.last  <= 1'b0;
      f_cnt <= f_cnt + CW'(push) - CW'(pop);
      if (push) begin
        wr_ix <= wr_ix == IW'(CREDITS - 1) ? '0 : wr_ix + 1'b1;
      end
      if (pop) begin
        rd_ix <= rd_ix == IW'(CREDITS - 1) ? '0 : rd_ix + 1'b1;
      end
      o_cnt <= o_cnt + CW'(out_beat.credit)
             - CW'(can_send && (state == HDR0 || state == HDR1 || pop
                                || (state == IDLE && have_frame)));
      case (state)
        IDLE: begin
          if (have_frame) begin
            state          <= can_send ? HDR1 : HDR0;
            out_beat.valid <= can_send;
          end
        end
        HDR0: begin
          if (can_send) begin
            state          <= HDR1;
            out_beat.valid <= 1'b1;
          end
        end
        HDR1: begin
          if (can_send) begin
            state          <= PAYLOAD;
            out_beat.valid <= 1'b1;
          end
        end
        default: begin
          if (pop) begin
            out_beat.valid <= 1'b1;
            out_beat.last  <= f_last[rd_ix];
            if (f_last[rd_ix]) begin
              state <= IDLE;
              seq   <= seq + 1'b1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      f_data[wr_ix] <= in_beat.data;
      f_last[wr_ix] <= in_beat.last;
      f_ip[wr_ix]   <= in_beat.dest_ip;
      f_port[wr_ix] <= in_beat.dest_port;
      f_len[wr_ix]  <= in_beat.len;
    end
    if (state == IDLE && have_frame) begin
      m_ip   <= src_ip;
      m_port <= src_port;
      m_len  <= src_len;
    end
    out_beat.dest_ip   <= state == IDLE ? src_ip : m_ip;
    out_beat.dest_port <= state == IDLE ? src_port : m_port;
    out_beat.len       <= (state == IDLE ? src_len : m_len) + len_t'(HDR_WORDS);
    case (state)
      IDLE:    out_beat.data <= hdr_word0(src_ip, src_port, local_port);
      HDR0:    out_beat.data <= hdr_word0(m_ip, m_port, local_port);
      HDR1:    out_beat.data <= hdr_word1(local_ip, m_len, seq);
      default: out_beat.data <= f_data[rd_ix];
    endcase
  end

  // Upstream credits must keep the holding FIFO from overfilling
  assert property (@(posedge clk) disable iff (mac_resetRR)
    push |-> f_cnt != CW'(CREDITS));

endmodule

// File: tge_tx_mac_out.sv
`timescale 1ns/1ps

module tge_tx_mac_out #(
  parameter int CREDITS   = 4,
  parameter int LED_WIDTH = 26
) (
  input  logic           clk,
  input  logic           mac_resetRR,
  input  logic           mac_tx_ready,
  output logic           mac_tx_valid,
  output tge_pkg::word_t mac_tx_data,
  output logic           mac_tx_last,
  output logic           led_tx,
  tge_beat_if.receiver   in_beat
);
  import tge_pkg::*;

  localparam int CW = $clog2(CREDITS + 1);
  localparam int IW = $clog2(CREDITS);

  word_t s_data [CREDITS];
  logic  s_last [CREDITS];

  logic [IW-1:0]        wr_ix, rd_ix;
  logic [CW-1:0]        s_cnt;
  logic                 xfer, first_beat;
  logic [LED_WIDTH-1:0] stretch;

  // Skid FIFO head drives the MAC stream directly
  assign mac_tx_valid = s_cnt != '0;
  assign mac_tx_data  = s_data[rd_ix];
  assign mac_tx_last  = s_last[rd_ix];
  assign xfer         = mac_tx_valid && mac_tx_ready;

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      wr_ix          <= '0;
      rd_ix          <= '0;
      s_cnt          <= '0;
      in_beat.credit <= 1'b0;
    end else begin
      in_beat.credit <= xfer;
      s_cnt <= s_cnt + CW'(in_beat.valid) - CW'(xfer);
      if (in_beat.valid) begin
        wr_ix <= wr_ix == IW'(CREDITS - 1) ? '0 : wr_ix + 1'b1;
      end
      if (xfer) begin
        rd_ix <= rd_ix == IW'(CREDITS - 1) ? '0 : rd_ix + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_beat.valid) begin
      s_data[wr_ix] <= in_beat.data;
      s_last[wr_ix] <= in_beat.last;
    end
  end

  // Activity LED, retriggered by each frame start
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      first_beat <= 1'b1;
      stretch    <= '0;
      led_tx     <= 1'b0;
    end else begin
      led_tx <= stretch[LED_WIDTH-1];
      if (xfer) begin
        first_beat <= mac_tx_last;
      end
      if (xfer && first_beat) begin
        stretch <= '1;
      end else if (stretch[LED_WIDTH-1]) begin
        stretch <= stretch - 1'b1;
      end
    end
  end

  // Upstream credit accounting must keep the FIFO from overfilling
  assert property (@(posedge clk) disable iff (mac_resetRR)
    in_beat.valid |-> s_cnt != CW'(CREDITS));

endmodule

// File: tge_tx_tb.sv
`timescale 1ns/1ps

module tge_tx_tb;
  import tge_pkg::*;

  logic  clk;
  logic  mac_resetRR;
  logic  tx_valid;
  logic  tx_end_of_frame;
  word_t tx_data;
  ip_t   tx_dest_ip;
  port_t tx_dest_port;
  logic  tx_overflow;
  logic  tx_afull;
  ip_t   local_ip;
  port_t local_port;
  logic  mac_tx_valid;
  word_t mac_tx_data;
  logic  mac_tx_last;
  logic  mac_tx_ready;
  logic  led_tx;

  // Expected MAC stream, one entry per word
  word_t exp_data[$];
  logic  exp_last[$];
  string exp_name[$];

  seq_t   exp_seq;
  integer seed = 32'h8ef0;
  integer rnd;
  logic   stall_mode;
  logic   hold_pending;
  word_t  hold_data;
  logic   afull_seen;
  logic   afull_at_ovf;
  logic   led_seen;
  int     ovf_count;
  int     ovf_expected;

  tge_tx_top #(
    .LED_WIDTH (4)
  ) uut (
    .clk             (clk),
    .mac_resetRR     (mac_resetRR),
    .tx_valid        (tx_valid),
    .tx_end_of_frame (tx_end_of_frame),
    .tx_data         (tx_data),
    .tx_dest_ip      (tx_dest_ip),
    .tx_dest_port    (tx_dest_port),
    .tx_overflow     (tx_overflow),
    .tx_afull        (tx_afull),
    .local_ip        (local_ip),
    .local_port      (local_port),
    .mac_tx_valid    (mac_tx_valid),
    .mac_tx_data     (mac_tx_data),
    .mac_tx_last     (mac_tx_last),
    .mac_tx_ready    (mac_tx_ready),
    .led_tx          (led_tx)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // MAC back-pressure, random only in stall tests
  always @(posedge clk) begin
    #2;
    rnd = $random(seed);
    mac_tx_ready = stall_mode ? rnd[0] : 1'b1;
  end

  // Output monitor against the model queue
  always @(posedge clk) begin
    if (!mac_resetRR) begin
      if (hold_pending) begin
        check("hold_valid", 64'd1, {63'd0, mac_tx_valid});
        check("hold_data", hold_data, mac_tx_data);
      end
      if (mac_tx_valid && mac_tx_ready) begin
        if (exp_data.size() == 0) begin
          abort_run("word on the MAC output while no word was expected");
        end else begin
          check(exp_name[0], exp_data[0], mac_tx_data);
          check(exp_name[0], {63'd0, exp_last[0]}, {63'd0, mac_tx_last});
          void'(exp_data.pop_front());
          void'(exp_last.pop_front());
          void'(exp_name.pop_front());
        end
      end
      hold_pending = mac_tx_valid && !mac_tx_ready;
      hold_data    = mac_tx_data;
      // tx_afull has to be seen on an earlier cycle than the overflow
      if (tx_overflow) begin
        ovf_count++;
        afull_at_ovf = afull_seen;
      end
      if (tx_afull) begin
        afull_seen = 1'b1;
      end
      if (led_tx) begin
        led_seen = 1'b1;
      end
    end
  end

  task automatic push_word(input string name, input word_t data, input logic last);
    exp_data.push_back(data);
    exp_last.push_back(last);
    exp_name.push_back(name);
  endtask

  // Two header words, then the payload
  task automatic expect_frame(input string name, input ip_t ip, input port_t port,
                              input int words, input word_t first);
    int i;
    push_word(name, {ip, port, local_port}, 1'b0);
    push_word(name, {local_ip, len_t'(words), exp_seq}, 1'b0);
    for (i = 0; i < words; i++) begin
      push_word(name, first + word_t'(i), i == words - 1);
    end
    exp_seq = exp_seq + 1'b1;
  endtask

  task automatic drive_frame(input ip_t ip, input port_t port, input int words,
                             input word_t first);
    int i;
    for (i = 0; i < words; i++) begin
      @(posedge clk);
      #2;
      tx_valid        = 1'b1;
      tx_end_of_frame = i == words - 1;
      tx_data         = first + word_t'(i);
      tx_dest_ip      = ip;
      tx_dest_port    = port;
    end
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #2;
    tx_valid        = 1'b0;
    tx_end_of_frame = 1'b0;
  endtask

  task automatic wait_drain(input string name);
    int n;
    n = 0;
    while (exp_data.size() != 0 && n < 2000) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (exp_data.size() != 0) begin
      abort_run($sformatf("%s: MAC output did not finish the frame in time", name));
    end
  endtask

  task automatic wait_overflow(input string name);
    int n;
    n = 0;
    while (ovf_count < ovf_expected && n < 20) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (ovf_count < ovf_expected) begin
      abort_run($sformatf("%s: tx_overflow never pulsed", name));
    end
  endtask

  task automatic wait_led_off();
    int n;
    n = 0;
    while (led_tx && n < 64) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (led_tx) begin
      abort_run("led_tx stayed high after the link went idle");
    end
  endtask

  task automatic run_test(input string name, input logic [63:0] kind, input ip_t ip,
                          input port_t port, input int words, input word_t first);
    if (kind == 64'("overflow")) begin
      // Start from an empty buffer so the frame alone fills it
      drive_idle();
      wait_drain(name);
      afull_seen = 1'b0;
      ovf_expected++;
      drive_frame(ip, port, words, first);
      drive_idle();
      wait_overflow(name);
      check(name, 64'd1, {63'd0, afull_at_ovf});
    end else if (kind == 64'("stall")) begin
      stall_mode = 1'b1;
      expect_frame(name, ip, port, words, first);
      drive_frame(ip, port, words, first);
      drive_idle();
      wait_drain(name);
      stall_mode = 1'b0;
    end else if (kind == 64'("frame")) begin
      expect_frame(name, ip, port, words, first);
      drive_frame(ip, port, words, first);
    end else begin
      abort_run($sformatf("%s: unknown test kind in the test file", name));
    end
  endtask

  initial begin : main
    int           fd;
    int           n;
    string        line;
    string        tname;
    logic [127:0] name_vec;
    logic [63:0]  kind_vec;
    ip_t          ip;
    port_t        port;
    int           words;
    word_t        first;

    mac_resetRR     = 1'b1;
    tx_valid        = 1'b0;
    tx_end_of_frame = 1'b0;
    tx_data         = '0;
    tx_dest_ip      = '0;
    tx_dest_port    = '0;
    local_ip        = 32'hc0a80001;
    local_port      = 16'h04d2;
    mac_tx_ready    = 1'b0;
    stall_mode      = 1'b0;
    hold_pending    = 1'b0;
    hold_data       = '0;
    afull_seen      = 1'b0;
    afull_at_ovf    = 1'b0;
    led_seen        = 1'b0;
    exp_seq         = '0;
    ovf_count       = 0;
    ovf_expected    = 0;

    repeat (3) @(posedge clk);
    #2;
    mac_resetRR = 1'b0;
    check("reset", 64'd0, {60'd0, mac_tx_valid, tx_overflow, tx_afull, led_tx});

    fd = $fopen("tge_tx_tests.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open tge_tx_tests.txt");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %s %h %h %d %h", name_vec, kind_vec, ip, port, words, first);
        if (n != 6) begin
          abort_run($sformatf("malformed line in the test file: %s", line));
        end
        tname = $sformatf("%0s", name_vec);
        run_test(tname, kind_vec, ip, port, words, first);
      end
    end
    $fclose(fd);

    drive_idle();
    wait_drain("final");
    check("overflows", 64'(ovf_expected), 64'(ovf_count));
    check("led_on", 64'd1, {63'd0, led_seen});
    wait_led_off();

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: tge_tx_tests.txt
# name kind dest_ip dest_port words first_word
# kind is frame, stall or overflow; ip, port and first_word in hex, words in decimal
one_word    frame    c0a80a01 1388 1  0123456789abcdef
four_words  frame    c0a80a02 1389 4  1000000000000000
eight       frame    0a000005 0035 8  20000000000000f0
b2b_a       frame    0a000006 2710 3  3000000000000000
b2b_b       frame    0a000007 2711 5  30000000000000fd
stall_mid   stall    ac100001 1f90 12 4000000000000000
stall_long  stall    ac100002 1f91 30 5000000000000000
stall_tiny  stall    ac100003 1f92 2  60000000ffffffff
after_stall frame    ac100004 1f93 6  7000000000000000
too_long    overflow c0a80063 0bb8 65 8000000000000000
post_ovf    frame    c0a80064 0bb9 7  9000000000000000
long_frame  frame    c0a80065 0bba 40 a000000000000000
stall_end   stall    ffffffff ffff 9  b000000000000000
last_one    frame    00000001 0001 3  fffffffffffffffe

// File: tge_tx_top.sv
`timescale 1ns/1ps

module tge_tx_top #(
  parameter int BUF_DEPTH = 64,
  parameter int AFULL_GAP = 8,
  parameter int CREDITS   = 4,
  parameter int LED_WIDTH = 26
) (
  input  logic           clk,
  input  logic           mac_resetRR,
  input  logic           tx_valid,
  input  logic           tx_end_of_frame,
  input  tge_pkg::word_t tx_data,
  input  tge_pkg::ip_t   tx_dest_ip,
  input  tge_pkg::port_t tx_dest_port,
  output logic           tx_overflow,
  output logic           tx_afull,
  input  tge_pkg::ip_t   local_ip,
  input  tge_pkg::port_t local_port,
  output logic           mac_tx_valid,
  output tge_pkg::word_t mac_tx_data,
  output logic           mac_tx_last,
  input  logic           mac_tx_ready,
  output logic           led_tx
);

  tge_beat_if hdr_link ();
  tge_beat_if out_link ();

  tge_tx_buffer #(
    .BUF_DEPTH (BUF_DEPTH),
    .AFULL_GAP (AFULL_GAP),
    .CREDITS   (CREDITS)
  ) u_buffer (
    .clk             (clk),
    .mac_resetRR     (mac_resetRR),
    .tx_valid        (tx_valid),
    .tx_end_of_frame (tx_end_of_frame),
    .tx_data         (tx_data),
    .tx_dest_ip      (tx_dest_ip),
    .tx_dest_port    (tx_dest_port),
    .tx_overflow     (tx_overflow),
    .tx_afull        (tx_afull),
    .hdr             (hdr_link.sender)
  );

  tge_tx_header #(
    .CREDITS (CREDITS)
  ) u_header (
    .clk         (clk),
    .mac_resetRR (mac_resetRR),
    .local_ip    (local_ip),
    .local_port  (local_port),
    .in_beat     (hdr_link.receiver),
    .out_beat    (out_link.sender)
  );

  tge_tx_mac_out #(
    .CREDITS   (CREDITS),
    .LED_WIDTH (LED_WIDTH)
  ) u_mac_out (
    .clk          (clk),
    .mac_resetRR  (mac_resetRR),
    .mac_tx_ready (mac_tx_ready),
    .mac_tx_valid (mac_tx_valid),
    .mac_tx_data  (mac_tx_data),
    .mac_tx_last  (mac_tx_last),
    .led_tx       (led_tx),
    .in_beat      (out_link.receiver)
  );

endmodule
